// ==== hw/mips_defs.svh ====
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// data path word width.
`define MIPS_WORD_W 32

// shift amount field width.
`define MIPS_SHAMT_W 5

// restoring divider iterations, one quotient bit per cycle.
`define MDU_DIV_STEPS 32

`endif

// ==== hw/mips_pkg.sv ====
`include "mips_defs.svh"

package mips_pkg;

    typedef logic [`MIPS_WORD_W-1:0] word_t;

    typedef enum logic [5:0] {
        ADD, ADDU, SUB, SUBU,
        AND, OR, XOR, NOR,
        SLT, SLTU,
        SLL, SRL, SRA,
        LUI, ADDI, ADDIU,
        BEQ, BNE, BLEZ, BGTZ, BLTZ, BGEZ,
        JAL,
        MULT, MULTU, DIV, DIVU,
        MFLO,
        NOP
    } decoded_op_t;

    // add/sub come in trapping and non-trapping flavours.
    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADD_NOCHECK, ALU_SUB, ALU_SUB_NOCHECK,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_LUI, ALU_PASS_A
    } alufunc_t;

    typedef enum logic {
        REGB,
        IMM
    } alusrc_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ
    } branch_type_t;

    typedef struct packed {
        alufunc_t     alufunc;
        alusrc_t      alusrc;
        logic         shamt_valid;   // operand a comes from shamt.
        branch_type_t branch_type;
        logic         is_link;       // writes pc+8.
        logic         mul_div_r;     // reads lo.
    } control_t;

    typedef struct packed {
        decoded_op_t               op;
        control_t                  ctl;
        logic [`MIPS_SHAMT_W-1:0]  shamt;
        word_t                     extended_imm;
    } decoded_instr_t;

    typedef struct packed {
        decoded_instr_t instr;
        word_t          pcplus4;
        word_t          srca;
        word_t          srcb;
        logic [4:0]     destreg;
    } issue_data_t;

    typedef struct packed {
        decoded_instr_t instr;
        word_t          pcplus4;
        word_t          srca;
        word_t          srcb;
        logic [4:0]     destreg;
        word_t          result;
        word_t          hiresult;
        word_t          loresult;
        logic           taken;
        logic           exception_of;
    } exec_data_t;

endpackage

// ==== hw/alu.sv ====
`timescale 1ns/10ps
`include "mips_defs.svh"

module alu (
    input  mips_pkg::word_t    a,
    input  mips_pkg::word_t    b,
    input  mips_pkg::alufunc_t func,
    output mips_pkg::word_t    y,
    output logic               overflow
);

    import mips_pkg::*;

    localparam int MSB  = `MIPS_WORD_W - 1;
    localparam int HALF = `MIPS_WORD_W / 2;

    word_t                    sum;
    word_t                    diff;
    logic [`MIPS_SHAMT_W-1:0] sa;

    assign sum  = a + b;
    assign diff = a - b;
    assign sa   = a[`MIPS_SHAMT_W-1:0];   // shift count from operand a.

    always_comb begin
        y        = '0;
        overflow = 1'b0;
        case (func)
            ALU_ADD: begin
                y        = sum;
                overflow = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);   // like signs in.
            end
            ALU_SUB: begin
                y        = diff;
                overflow = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);  // unlike signs in.
            end
            ALU_ADD_NOCHECK: y = sum;
            ALU_SUB_NOCHECK: y = diff;
            ALU_AND:         y = a & b;
            ALU_OR:          y = a | b;
            ALU_XOR:         y = a ^ b;
            ALU_NOR:         y = ~(a | b);
            ALU_SLT:         y = word_t'($signed(a) < $signed(b));
            ALU_SLTU:        y = word_t'(a < b);
            ALU_SLL:         y = b << sa;
            ALU_SRL:         y = b >> sa;
            ALU_SRA:         y = word_t'($signed(b) >>> sa);
            ALU_LUI:         y = {b[HALF-1:0], {HALF{1'b0}}};
            ALU_PASS_A:      y = a;
            default:         y = '0;
        endcase
    end

endmodule

// ==== hw/branch_judge.sv ====
`timescale 1ns/10ps
`include "mips_defs.svh"

module branch_judge (
    input  mips_pkg::word_t        a,
    input  mips_pkg::word_t        b,
    input  mips_pkg::branch_type_t branch_type,
    output logic                   taken
);

    import mips_pkg::*;

    logic a_neg;
    logic a_zero;

    assign a_neg  = a[`MIPS_WORD_W-1];
    assign a_zero = (a == '0);

    always_comb begin
        case (branch_type)
            BR_EQ:   taken = (a == b);
            BR_NE:   taken = (a != b);
            BR_LEZ:  taken = a_neg | a_zero;
            BR_GTZ:  taken = ~a_neg & ~a_zero;
            BR_LTZ:  taken = a_neg;
            BR_GEZ:  taken = ~a_neg;
            default: taken = 1'b0;   // not a branch.
        endcase
    end

endmodule

// ==== hw/mul_div_unit.sv ====
`timescale 1ns/10ps
`include "mips_defs.svh"

module mul_div_unit (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic                  first_cycle,
    input  logic                  en,
    input  mips_pkg::decoded_op_t op,
    input  mips_pkg::word_t       a,
    input  mips_pkg::word_t       b,
    output mips_pkg::word_t       hi,
    output mips_pkg::word_t       lo,
    output logic                  ok
);

    import mips_pkg::*;

    localparam int W     = `MIPS_WORD_W;
    localparam int CNT_W = $clog2(`MDU_DIV_STEPS + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUSY,
        S_DONE
    } state_t;

    state_t           state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             ok_q;
    word_t            hi_q, lo_q;
    word_t            rem_q, quo_q, dvsr_q;
    logic             neg_q_q, neg_r_q, dz_q;

    logic             start, is_mul, is_signed, stepping;
    word_t            mag_a, mag_b, q_fix, r_fix;
    logic [2*W-1:0]   prod_s, prod_u, prod;
    logic [W:0]       rem_sh, trial;

    assign start     = en & first_cycle & ~flush;
    assign is_mul    = (op == MULT) || (op == MULTU);
    assign is_signed = (op == MULT) || (op == DIV);
    assign stepping  = (state_q == S_BUSY) && (cnt_q != CNT_W'(`MDU_DIV_STEPS));

    assign mag_a = (is_signed && a[W-1]) ? -a : a;
    assign mag_b = (is_signed && b[W-1]) ? -b : b;

    assign prod_s = {{W{a[W-1]}}, a} * {{W{b[W-1]}}, b};   // low 2w bits are exact.
    assign prod_u = {{W{1'b0}}, a} * {{W{1'b0}}, b};
    assign prod   = (op == MULT) ? prod_s : prod_u;

    // one restoring step.
    assign rem_sh = {rem_q, quo_q[W-1]};
    assign trial  = rem_sh - {1'b0, dvsr_q};

    assign q_fix = neg_q_q ? -quo_q : quo_q;
    assign r_fix = neg_r_q ? -rem_q : rem_q;   // remainder follows the dividend.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
            ok_q    <= 1'b0;
            hi_q    <= '0;
            lo_q    <= '0;
        end else if (flush) begin
            state_q <= S_IDLE;   // hi/lo keep their value.
            ok_q    <= 1'b0;
        end else if (start) begin
            cnt_q <= '0;
            if (is_mul) begin
                hi_q    <= prod[2*W-1:W];
                lo_q    <= prod[W-1:0];
                ok_q    <= 1'b1;
                state_q <= S_DONE;
            end else begin
                ok_q    <= 1'b0;
                state_q <= S_BUSY;
            end
        end else if (state_q == S_BUSY) begin
            if (stepping) begin
                cnt_q <= cnt_q + 1'b1;
            end else begin
                hi_q    <= r_fix;
                lo_q    <= dz_q ? '1 : q_fix;   // divide by zero gives all ones.
                ok_q    <= 1'b1;
                state_q <= S_DONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quo_q   <= mag_a;   // dividend shifts out as quotient shifts in.
            rem_q   <= '0;
            dvsr_q  <= mag_b;
            neg_q_q <= is_signed & (a[W-1] ^ b[W-1]);
            neg_r_q <= is_signed & a[W-1];
            dz_q    <= (b == '0);
        end else if (stepping) begin
            quo_q <= {quo_q[W-2:0], ~trial[W]};
            rem_q <= trial[W] ? rem_sh[W-1:0] : trial[W-1:0];
        end
    end

    assign hi = hi_q;
    assign lo = lo_q;
    assign ok = ok_q;

    a_no_ok_while_busy: assert property (
        @(posedge clk) disable iff (!arst_n) (state_q == S_BUSY) |-> !ok_q
    ) else $error("mdu reports completion while still dividing");

    // the issuing side has to hold the instruction until finish.
    a_op_held: assert property (
        @(posedge clk) disable iff (!arst_n) (state_q == S_BUSY && !flush) |-> $stable(op)
    ) else $error("mdu op changed during a divide");

endmodule

// ==== hw/fu.sv ====
`timescale 1ns/10ps
`include "mips_defs.svh"

module fu (
    input  logic                  first_cycle,
    input  mips_pkg::issue_data_t in,
    output mips_pkg::exec_data_t  out,
    output logic                  finish,
    output mips_pkg::word_t       mult_src_a,
    output mips_pkg::word_t       mult_src_b,
    output mips_pkg::decoded_op_t mult_op,
    output logic                  mult_en,
    input  mips_pkg::word_t       hi,
    input  mips_pkg::word_t       lo,
    input  logic                  mult_ok
);

    import mips_pkg::*;

    decoded_op_t op;
    control_t    ctl;
    word_t       src_a, src_b, alu_y, pcplus8;
    logic        alu_of, taken, is_mul, is_div;

    assign op     = in.instr.op;
    assign ctl    = in.instr.ctl;
    assign is_mul = (op == MULT) || (op == MULTU);
    assign is_div = (op == DIV) || (op == DIVU);

    assign src_a = ctl.shamt_valid ?
                   {{(`MIPS_WORD_W - `MIPS_SHAMT_W){1'b0}}, in.instr.shamt} : in.srca;
    assign src_b = (ctl.alusrc == REGB) ? in.srcb : in.instr.extended_imm;

    alu alu0 (
        .a        (src_a),
        .b        (src_b),
        .func     (ctl.alufunc),
        .y        (alu_y),
        .overflow (alu_of)
    );

    branch_judge judge0 (
        .a           (src_a),
        .b           (src_b),
        .branch_type (ctl.branch_type),
        .taken       (taken)
    );

    assign mult_src_a = src_a;
    assign mult_src_b = src_b;
    assign mult_op    = op;
    assign mult_en    = is_mul | is_div;   // level for as long as the op is held.

    // mul/div waits for the unit; first cycle never counts.
    assign finish  = ~mult_en | (mult_ok & ~first_cycle);
    assign pcplus8 = in.pcplus4 + word_t'(4);

    always_comb begin
        out.instr        = in.instr;
        out.pcplus4      = in.pcplus4;
        out.srca         = in.srca;
        out.srcb         = in.srcb;
        out.destreg      = in.destreg;
        out.taken        = taken;
        out.result       = ctl.is_link ? pcplus8 : (ctl.mul_div_r ? lo : alu_y);
        out.hiresult     = mult_en ? hi : alu_y;
        out.loresult     = mult_en ? lo : alu_y;
        out.exception_of = mult_en ? 1'b0 : alu_of;
    end

endmodule

// ==== hw/exec_stage.sv ====
`timescale 1ns/10ps

module exec_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic                  first_cycle,
    input  mips_pkg::issue_data_t in,
    output mips_pkg::exec_data_t  out,
    output logic                  finish
);

    import mips_pkg::*;

    word_t       mult_src_a, mult_src_b;
    word_t       hi, lo;
    decoded_op_t mult_op;
    logic        mult_en, mult_ok;

    fu fu0 (
        .first_cycle (first_cycle),
        .in          (in),
        .out         (out),
        .finish      (finish),
        .mult_src_a  (mult_src_a),
        .mult_src_b  (mult_src_b),
        .mult_op     (mult_op),
        .mult_en     (mult_en),
        .hi          (hi),
        .lo          (lo),
        .mult_ok     (mult_ok)
    );

    mul_div_unit mdu0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .first_cycle (first_cycle),
        .en          (mult_en),
        .op          (mult_op),
        .a           (mult_src_a),
        .b           (mult_src_b),
        .hi          (hi),
        .lo          (lo),
        .ok          (mult_ok)
    );

endmodule

// ==== verification/exec_stage_vectors.svh ====
`ifndef EXEC_STAGE_VECTORS_SVH
`define EXEC_STAGE_VECTORS_SVH

// control flags are {shamt_valid, is_link, mul_div_r}.
// columns: name, op, control, shamt, imm, pcplus4, srca, srcb,
// result, taken, overflow, hi, lo.
task automatic load_vectors();
    add_vec("add", ADD, control_of(ALU_ADD, REGB, BR_NONE, 3'b000),
            '0, '0, '0, 32'h7, 32'h5, 32'hc, 1'b0, 1'b0, '0, '0);
    add_vec("add_ovf", ADD, control_of(ALU_ADD, REGB, BR_NONE, 3'b000),
            '0, '0, '0, 32'h7fff_ffff, 32'h1, 32'h8000_0000, 1'b0, 1'b1, '0, '0);
    add_vec("addu_no_ovf", ADDU, control_of(ALU_ADD_NOCHECK, REGB, BR_NONE, 3'b000),
            '0, '0, '0, 32'h7fff_ffff, 32'h1, 32'h8000_0000, 1'b0, 1'b0, '0, '0);
    add_vec("sub_ovf", SUB, control_of(ALU_SUB, REGB, BR_NONE, 3'b000),
            '0, '0, '0, 32'h8000_0000, 32'h1, 32'h7fff_ffff, 1'b0, 1'b1, '0, '0);
    add_vec("addi_neg", ADDI, control_of(ALU_ADD, IMM, BR_NONE, 3'b000),
            '0, 32'hffff_fffc, '0, 32'ha, 32'h55, 32'h6, 1'b0, 1'b0, '0, '0);
    add_vec("slt", SLT, control_of(ALU_SLT, REGB, BR_NONE, 3'b000),
            '0, '0, '0, 32'hffff_fffe, 32'h3, 32'h1, 1'b0, 1'b0, '0, '0);
    add_vec("sltu", SLTU, control_of(ALU_SLTU, REGB, BR_NONE, 3'b000),
            '0, '0, '0, 32'hffff_fffe, 32'h3, 32'h0, 1'b0, 1'b0, '0, '0);
    add_vec("sll", SLL, control_of(ALU_SLL, REGB, BR_NONE, 3'b100),
            5'd4, '0, '0, 32'hffff_ffff, 32'h1234, 32'h1_2340, 1'b0, 1'b0, '0, '0);
    add_vec("sra", SRA, control_of(ALU_SRA, REGB, BR_NONE, 3'b100),
            5'd8, '0, '0, '0, 32'h8000_0000, 32'hff80_0000, 1'b0, 1'b0, '0, '0);
    add_vec("lui", LUI, control_of(ALU_LUI, IMM, BR_NONE, 3'b000),
            '0, 32'h1234, '0, 32'h9, '0, 32'h1234_0000, 1'b0, 1'b0, '0, '0);
    add_vec("beq", BEQ, control_of(ALU_SUB_NOCHECK, REGB, BR_EQ, 3'b000),
            '0, '0, '0, 32'h5, 32'h5, 32'h0, 1'b1, 1'b0, '0, '0);
    add_vec("bne", BNE, control_of(ALU_SUB_NOCHECK, REGB, BR_NE, 3'b000),
            '0, '0, '0, 32'h5, 32'h5, 32'h0, 1'b0, 1'b0, '0, '0);
    add_vec("blez", BLEZ, control_of(ALU_SUB_NOCHECK, REGB, BR_LEZ, 3'b000),
            '0, '0, '0, 32'h0, 32'h0, 32'h0, 1'b1, 1'b0, '0, '0);
    add_vec("bgtz", BGTZ, control_of(ALU_SUB_NOCHECK, REGB, BR_GTZ, 3'b000),
            '0, '0, '0, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, '0, '0);
    add_vec("bltz", BLTZ, control_of(ALU_SUB_NOCHECK, REGB, BR_LTZ, 3'b000),
            '0, '0, '0, 32'hffff_ffff, 32'h0, 32'hffff_ffff, 1'b1, 1'b0, '0, '0);
    add_vec("bgez", BGEZ, control_of(ALU_SUB_NOCHECK, REGB, BR_GEZ, 3'b000),
            '0, '0, '0, 32'h8000_0000, 32'h0, 32'h8000_0000, 1'b0, 1'b0, '0, '0);
    add_vec("jal", JAL, control_of(ALU_PASS_A, REGB, BR_NONE, 3'b010),
            '0, '0, 32'h0040_0104, '0, '0, 32'h0040_0108, 1'b0, 1'b0, '0, '0);
    add_vec("mult", MULT, control_of(ALU_PASS_A, REGB, BR_NONE, 3'b000),
            '0, '0, '0, 32'hffff_fffd, 32'h7, '0, 1'b0, 1'b0, 32'hffff_ffff, 32'hffff_ffeb);
    add_vec("mflo", MFLO, control_of(ALU_PASS_A, REGB, BR_NONE, 3'b001),
            '0, '0, '0, '0, '0, 32'hffff_ffeb, 1'b0, 1'b0, '0, '0);
    add_vec("multu", MULTU, control_of(ALU_PASS_A, REGB, BR_NONE, 3'b000),
            '0, '0, '0, 32'hffff_ffff, 32'h2, '0, 1'b0, 1'b0, 32'h1, 32'hffff_fffe);
    add_vec("div_neg", DIV, control_of(ALU_PASS_A, REGB, BR_NONE, 3'b000),
            '0, '0, '0, 32'hffff_fff9, 32'h2, '0, 1'b0, 1'b0, 32'hffff_ffff, 32'hffff_fffd);
    add_vec("divu", DIVU, control_of(ALU_PASS_A, REGB, BR_NONE, 3'b000),
            '0, '0, '0, 32'd100, 32'd7, '0, 1'b0, 1'b0, 32'h2, 32'he);
    add_vec("div_zero", DIV, control_of(ALU_PASS_A, REGB, BR_NONE, 3'b000),
            '0, '0, '0, 32'h1234_5678, '0, '0, 1'b0, 1'b0, 32'h1234_5678, 32'hffff_ffff);
    // the add control would overflow here, a mul/div never reports it.
    add_vec("mult_of_masked", MULT, control_of(ALU_ADD, REGB, BR_NONE, 3'b000),
            '0, '0, '0, 32'h7fff_ffff, 32'h1, '0, 1'b0, 1'b0, 32'h0, 32'h7fff_ffff);
endtask

`endif

// ==== verification/exec_stage_tb.sv ====
`timescale 1ns/10ps
`include "mips_defs.svh"

module exec_stage_tb;

    import mips_pkg::*;

    localparam int TIMEOUT = 100;

    typedef struct packed {
        decoded_op_t op;
        control_t    ctl;
        logic [4:0]  shamt;
        word_t       imm;
        word_t       pcplus4;
        word_t       srca;
        word_t       srcb;
        word_t       exp_result;
        logic        exp_taken;
        logic        exp_of;
        word_t       exp_hi;
        word_t       exp_lo;
    } vector_t;

    logic        clk, arst_n, flush, first_cycle, finish;
    issue_data_t in;
    exec_data_t  out;

    vector_t     vectors[$];
    string       names[$];
    int          pass_cnt, fail_cnt;
    word_t       lcg_state, model_lo;
    decoded_op_t md_ops[4] = '{MULT, MULTU, DIV, DIVU};

    exec_stage dut0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .first_cycle (first_cycle),
        .in          (in),
        .out         (out),
        .finish      (finish)
    );

    always #5 clk = ~clk;

    // flags are {shamt_valid, is_link, mul_div_r}.
    function automatic control_t control_of(input alufunc_t f, input alusrc_t s,
                                            input branch_type_t br, input logic [2:0] flags);
        return '{alufunc: f, alusrc: s, shamt_valid: flags[2], branch_type: br,
                 is_link: flags[1], mul_div_r: flags[0]};
    endfunction

    task automatic add_vec(input string name, input decoded_op_t op, input control_t ctl,
                           input logic [4:0] shamt, input word_t imm, input word_t pc,
                           input word_t a, input word_t b, input word_t res, input logic tk,
                           input logic ovf, input word_t hi, input word_t lo);
        vector_t v;
        v = '{op, ctl, shamt, imm, pc, a, b, res, tk, ovf, hi, lo};
        names.push_back(name);
        vectors.push_back(v);
    endtask

    `include "exec_stage_vectors.svh"

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // expected hi/lo straight from the mul/div rules.
    function automatic vector_t md_vector(input decoded_op_t op, input word_t a,
                                          input word_t b);
        vector_t     v;
        longint      sa;
        longint      sb;
        logic [63:0] p;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        case (op)
            MULT:    p = 64'(sa * sb);
            MULTU:   p = {32'h0, a} * {32'h0, b};
            DIV:     p = (b == '0) ? {a, 32'hffff_ffff} : {32'(sa % sb), 32'(sa / sb)};
            default: p = (b == '0) ? {a, 32'hffff_ffff} : {a % b, a / b};
        endcase
        v = '{op, control_of(ALU_PASS_A, REGB, BR_NONE, 3'b000), 5'd0, '0, '0, a, b,
              '0, 1'b0, 1'b0, p[63:32], p[31:0]};
        return v;
    endfunction

    task automatic drive(input vector_t v);
        in                    = '0;
        in.instr.op           = v.op;
        in.instr.ctl          = v.ctl;
        in.instr.shamt        = v.shamt;
        in.instr.extended_imm = v.imm;
        in.pcplus4            = v.pcplus4;
        in.srca               = v.srca;
        in.srcb               = v.srcb;
        in.destreg            = 5'(pass_cnt + fail_cnt + 1);   // differs per test.
    endtask

    // cycles counts the instruction's cycles up to the one with finish.
    task automatic apply(input vector_t v, output int cycles, output logic timed_out);
        @(negedge clk);
        drive(v);
        first_cycle = 1'b1;
        #1;
        cycles = 1;
        if (!finish) begin
            @(negedge clk);
            first_cycle = 1'b0;
            #1;
            cycles = 2;
            while (!finish && cycles < TIMEOUT) begin
                @(negedge clk);
                #1;
                cycles++;
            end
        end
        timed_out = !finish;
    endtask

    task automatic check_word(input string name, input string what, input word_t exp,
                              input word_t act, inout int errs);
        a_word: assert (act === exp) else begin
            $display("Fail %s %s: expected %h, actual %h", name, what, exp, act);
            errs++;
        end
    endtask

    // payload fields travel through unchanged.
    task automatic check_passthrough(input string name, inout int errs);
        issue_data_t act;
        act = {out.instr, out.pcplus4, out.srca, out.srcb, out.destreg};
        a_pass: assert (act === in) else begin
            $display("Fail %s payload: expected %h, actual %h", name, in, act);
            errs++;
        end
    endtask

    task automatic tally(input string name, input int errs);
        if (errs == 0) begin
            pass_cnt++;
            $display("ok   %s", name);
        end else begin
            fail_cnt++;
            $display("bad  %s, %0d checks failed", name, errs);
        end
    endtask

    task automatic run_and_check(input string name, input vector_t v);
        logic md;
        logic timed_out;
        int   cycles;
        int   exp_cycles;
        int   errs;
        md         = v.op inside {MULT, MULTU, DIV, DIVU};
        exp_cycles = !md ? 1 : ((v.op inside {MULT, MULTU}) ? 2 : `MDU_DIV_STEPS + 3);
        errs       = 0;
        apply(v, cycles, timed_out);
        if (timed_out) begin
            $display("%s: finish did not come within %0d cycles", name, TIMEOUT);
            errs++;
        end else begin
            check_word(name, "cycles", word_t'(exp_cycles), word_t'(cycles), errs);
            check_word(name, "overflow", word_t'(v.exp_of), word_t'(out.exception_of), errs);
            check_passthrough(name, errs);
            if (md) begin
                check_word(name, "hi", v.exp_hi, out.hiresult, errs);
                check_word(name, "lo", v.exp_lo, out.loresult, errs);
                model_lo = v.exp_lo;   // lo now holds this op's result.
            end else begin
                check_word(name, "result", v.exp_result, out.result, errs);
                check_word(name, "taken", word_t'(v.exp_taken), word_t'(out.taken), errs);
                if (!v.ctl.is_link && !v.ctl.mul_div_r) begin
                    check_word(name, "hi", v.exp_result, out.hiresult, errs);
                    check_word(name, "lo", v.exp_result, out.loresult, errs);
                end
            end
        end
        tally(name, errs);
    endtask

    task automatic random_batch();
        word_t a;
        word_t b;
        word_t sel;
        for (int i = 0; i < 16; i++) begin
            a   = lcg_next();
            b   = lcg_next();
            sel = lcg_next();
            b   = b >> sel[23:20];   // spread divisor sizes.
            run_and_check($sformatf("rand_%0d", i), md_vector(md_ops[sel[17:16]], a, b));
        end
    endtask

    task automatic flush_check();
        vector_t div_v;
        vector_t mflo_v;
        int      errs;
        logic    seen_finish;
        errs        = 0;
        seen_finish = 1'b0;
        div_v       = md_vector(DIV, 32'd1000, 32'd3);
        mflo_v = '{MFLO, control_of(ALU_PASS_A, REGB, BR_NONE, 3'b001), 5'd0, '0, '0, '0,
                   '0, model_lo, 1'b0, 1'b0, '0, '0};
        @(negedge clk);
        drive(div_v);
        first_cycle = 1'b1;
        @(negedge clk);
        first_cycle = 1'b0;
        repeat (4) @(negedge clk);
        flush = 1'b1;   // divide is mid-way here.
        @(negedge clk);
        flush = 1'b0;
        // hold the divide past its full run time.
        repeat (`MDU_DIV_STEPS + 2) begin
            #1;
            seen_finish = seen_finish | finish;
            @(negedge clk);
        end
        a_flushed: assert (!seen_finish) else begin
            $display("flush_div_abort: the divide still completed after the flush");
            errs++;
        end
        tally("flush_div_abort", errs);
        run_and_check("flush_mflo", mflo_v);
        run_and_check("flush_div", div_v);
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        flush       = 1'b0;
        first_cycle = 1'b0;
        in          = '0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        model_lo    = '0;
        lcg_state   = 32'd82277;
        load_vectors();
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        foreach (vectors[i]) begin
            run_and_check(names[i], vectors[i]);
        end
        random_batch();
        flush_check();
        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== mips_exec.f ====
+incdir+hw
+incdir+verification
hw/mips_pkg.sv
hw/alu.sv
hw/branch_judge.sv
hw/mul_div_unit.sv
hw/fu.sv
hw/exec_stage.sv
verification/exec_stage_tb.sv
